//--- rtl/heap_defs.svh
/*
  Sizes of the array heap. ARRAYS and LENGTH must equal 2**ARRAY_BITS and
  2**INDEX_BITS, and an array number must fit in INDEX_BITS+1 bits.
*/
`ifndef HEAP_DEFS_SVH
`define HEAP_DEFS_SVH

// ----------------------------------------------------------
// Geometry
// ----------------------------------------------------------
`define HEAP_ARRAY_BITS 3           // 8 arrays
`define HEAP_INDEX_BITS 3           // 8 elements per array
`define HEAP_DATA_BITS  16          // Element width
`define HEAP_ARRAYS     8
`define HEAP_LENGTH     8           // Capacity of one array

// ----------------------------------------------------------
// Pipeline and command set
// ----------------------------------------------------------
`define HEAP_LATENCY    3           // Command to response, in cycles
`define HEAP_OPCODES    18          // Members of heapOp

`endif

//--- rtl/heapPkg.sv
/*
  Command, checked-operation and result types of the array heap.
  Opcode encodings are sparse and fixed by the command set.
*/
`include "heap_defs.svh"

package heapPkg;

  typedef enum logic [4:0] {
    opWrite      = 5'd2,
    opRead       = 5'd3,
    opSize       = 5'd4,
    opPush       = 5'd14,
    opPop        = 5'd15,
    opAlloc      = 5'd18,
    opFree       = 5'd19,
    opAdd        = 5'd20,           // Returns the new value
    opAddAfter   = 5'd21,           // Returns the old value
    opSubtract   = 5'd22,
    opSubAfter   = 5'd23,
    opShiftLeft  = 5'd24,
    opShiftRight = 5'd25,
    opNotLogical = 5'd26,
    opNot        = 5'd27,
    opOr         = 5'd28,
    opXor        = 5'd29,
    opAnd        = 5'd30
  } heapOp;

  typedef enum logic [2:0] {
    errNone, errNotAllocated, errOutOfBounds, errFull, errEmpty, errOutOfMemory, errDoubleFree
  } heapError;

  typedef struct packed {
    heapOp                        op;
    logic [`HEAP_ARRAY_BITS-1:0]  array;
    logic [`HEAP_INDEX_BITS-1:0]  index;
    logic [`HEAP_DATA_BITS-1:0]   operand;
  } heapCmd;

  typedef struct packed {
    logic                         valid;
    heapOp                        op;
    logic [`HEAP_ARRAY_BITS-1:0]  array;
    logic [`HEAP_INDEX_BITS-1:0]  slot;       // Element actually touched
    logic [`HEAP_DATA_BITS-1:0]   operand;
    logic [`HEAP_INDEX_BITS:0]    sizeValue;  // Array size, or new array for Alloc
    heapError                     error;
  } checkedOp;

  typedef struct packed {
    logic                         valid;
    logic                         loadOut;    // Result word carries data
    logic [`HEAP_DATA_BITS-1:0]   value;
    heapError                     error;
  } heapResult;

  // Read-modify-write element operators
  function automatic logic isOperator(heapOp op);
    return op inside {opAdd, opAddAfter, opSubtract, opSubAfter, opShiftLeft,
                      opShiftRight, opNotLogical, opNot, opOr, opXor, opAnd};
  endfunction

endpackage

//--- rtl/elementAlu.sv
/*
  Combinational element operators. Results wrap at the data width and
  shift amounts come from the operand.
*/
`timescale 1ns/1ps
`include "heap_defs.svh"

module elementAlu import heapPkg::*; (
  input  heapOp                       op,
  input  logic [`HEAP_DATA_BITS-1:0]  element,
  input  logic [`HEAP_DATA_BITS-1:0]  operand,
  output logic [`HEAP_DATA_BITS-1:0]  newValue,
  output logic [`HEAP_DATA_BITS-1:0]  returned
);

  localparam logic [`HEAP_DATA_BITS-1:0] One = 1;

  always_comb begin
    case (op)
      opAdd, opAddAfter: begin
        newValue = element + operand;
      end
      opSubtract, opSubAfter: begin
        newValue = element - operand;
      end
      opShiftLeft: begin
        newValue = element << operand;                           // Zero once past the width
      end
      opShiftRight: begin
        newValue = element >> operand;
      end
      opNotLogical: begin
        newValue = (element == '0) ? One : '0;
      end
      opNot: begin
        newValue = ~element;
      end
      opOr: begin
        newValue = element | operand;
      end
      opXor: begin
        newValue = element ^ operand;
      end
      opAnd: begin
        newValue = element & operand;
      end
      default: begin
        newValue = element;                                      // Not an operator
      end
    endcase
  end

  // After forms hand back the value before the update
  assign returned = (op == opAddAfter || op == opSubAfter) ? element : newValue;

endmodule

//--- rtl/arrayAllocator.sv
/*
  Input stage. Checks each command against the allocation state and
  updates tables, sizes and free stack on the same edge that registers opOut.
  Only one error is reported per command, in fixed priority order.
*/
`timescale 1ns/1ps
`include "heap_defs.svh"

module arrayAllocator import heapPkg::*; (
  input  logic     clock,
  input  logic     resetN,
  input  logic     cmdValid,
  input  heapCmd   cmd,
  output checkedOp opOut
);

  localparam logic [`HEAP_INDEX_BITS:0] Capacity   = `HEAP_LENGTH;
  localparam logic [`HEAP_ARRAY_BITS:0] ArrayCount = `HEAP_ARRAYS;

  logic [`HEAP_ARRAYS-1:0]      allocated;                     // One bit per array
  logic [`HEAP_INDEX_BITS:0]    sizes     [`HEAP_ARRAYS];
  logic [`HEAP_ARRAY_BITS-1:0]  freeStack [`HEAP_ARRAYS];      // LIFO of freed arrays
  logic [`HEAP_ARRAY_BITS:0]    freeTop;
  logic [`HEAP_ARRAY_BITS:0]    nextNew;                       // Next never-used array

  logic [`HEAP_INDEX_BITS:0]    curSize;
  logic [`HEAP_INDEX_BITS:0]    sizeBelow;
  logic [`HEAP_INDEX_BITS:0]    wideIndex;
  logic [`HEAP_ARRAY_BITS:0]    topBelow;
  logic                         neverAllocated;
  logic                         isFreed;
  logic                         reuseFreed;
  logic                         isElementOp;
  logic [`HEAP_ARRAY_BITS-1:0]  allocArray;
  logic [`HEAP_INDEX_BITS-1:0]  slot;
  logic [`HEAP_INDEX_BITS:0]    sizeValue;
  heapError                     checkError;

  // ----------------------------------------------------------
  // Lookups for the current command
  // ----------------------------------------------------------
  assign curSize        = sizes[cmd.array];
  assign sizeBelow      = curSize - 1'b1;
  assign wideIndex      = {1'b0, cmd.index};
  assign topBelow       = freeTop - 1'b1;
  assign neverAllocated = {1'b0, cmd.array} >= nextNew;
  assign isFreed        = !allocated[cmd.array];
  assign reuseFreed     = freeTop != '0;                         // Freed arrays go first
  assign isElementOp    = cmd.op == opRead || isOperator(cmd.op);
  assign allocArray     = reuseFreed ? freeStack[topBelow[`HEAP_ARRAY_BITS-1:0]]
                                     : nextNew[`HEAP_ARRAY_BITS-1:0];

  always_comb begin
    checkError = errNone;
    if (cmd.op != opAlloc && (neverAllocated || (isFreed && cmd.op != opFree))) begin
      checkError = errNotAllocated;
    end else if (cmd.op == opFree && isFreed) begin
      checkError = errDoubleFree;
    end else if (isElementOp && wideIndex >= curSize) begin
      checkError = errOutOfBounds;
    end else if (cmd.op == opWrite && wideIndex >= Capacity) begin
      checkError = errOutOfBounds;                               // Only if LENGTH < 2**INDEX_BITS
    end else if (cmd.op == opPush && curSize == Capacity) begin
      checkError = errFull;
    end else if (cmd.op == opPop && curSize == '0) begin
      checkError = errEmpty;
    end else if (cmd.op == opAlloc && !reuseFreed && nextNew == ArrayCount) begin
      checkError = errOutOfMemory;
    end
  end

  always_comb begin
    slot      = cmd.index;
    sizeValue = curSize;
    case (cmd.op)
      opPush:  slot = curSize[`HEAP_INDEX_BITS-1:0];             // One past the top
      opPop:   slot = sizeBelow[`HEAP_INDEX_BITS-1:0];
      opAlloc: sizeValue = (`HEAP_INDEX_BITS+1)'(allocArray);    // Alloc returns the array
      default: ;
    endcase
  end

  // ----------------------------------------------------------
  // State update and output register
  // ----------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated <= '0;
      freeTop   <= '0;
      nextNew   <= '0;
      opOut     <= '0;
      for (int i = 0; i < `HEAP_ARRAYS; i++) begin
        sizes[i] <= '0;
      end
    end else begin
      opOut <= '{valid: cmdValid, op: cmd.op, array: cmd.array, slot: slot,
                 operand: cmd.operand, sizeValue: sizeValue, error: checkError};
      if (cmdValid && checkError == errNone) begin
        case (cmd.op)
          opAlloc: begin
            allocated[allocArray] <= 1'b1;
            sizes[allocArray]     <= '0;                         // New arrays start empty
            if (reuseFreed) begin
              freeTop <= topBelow;
            end else begin
              nextNew <= nextNew + 1'b1;
            end
          end
          opFree: begin
            allocated[cmd.array] <= 1'b0;
            freeTop              <= freeTop + 1'b1;
          end
          opWrite: begin
            if (wideIndex >= curSize) begin
              sizes[cmd.array] <= wideIndex + 1'b1;              // Grow to cover the index
            end
          end
          opPush:  sizes[cmd.array] <= curSize + 1'b1;
          opPop:   sizes[cmd.array] <= sizeBelow;
          default: ;
        endcase
      end
    end
  end

  // Only entries below freeTop hold freed arrays
  always_ff @(posedge clock) begin
    if (cmdValid && checkError == errNone && cmd.op == opFree) begin
      freeStack[freeTop[`HEAP_ARRAY_BITS-1:0]] <= cmd.array;
    end
  end

endmodule

//--- rtl/elementStore.sv
/*
  Element memory with one read-modify-write per cycle. The read is
  combinational, so a following operation sees the write of this one.
  Only error-free operations change the memory.
*/
`timescale 1ns/1ps
`include "heap_defs.svh"

module elementStore import heapPkg::*; (
  input  logic      clock,
  input  logic      resetN,
  input  checkedOp  opIn,
  output heapResult result
);

  localparam int Depth = `HEAP_ARRAYS * `HEAP_LENGTH;

  logic [`HEAP_DATA_BITS-1:0]                  memory [Depth];  // Fixed block per array
  logic [`HEAP_ARRAY_BITS+`HEAP_INDEX_BITS-1:0] address;
  logic [`HEAP_DATA_BITS-1:0]                  element;
  logic [`HEAP_DATA_BITS-1:0]                  newValue;
  logic [`HEAP_DATA_BITS-1:0]                  returned;
  logic [`HEAP_DATA_BITS-1:0]                  writeData;
  logic                                        doWrite;
  heapResult                                   nextResult;

  assign address = {opIn.array, opIn.slot};
  assign element = memory[address];

  elementAlu alu (
    .op       (opIn.op),
    .element  (element),
    .operand  (opIn.operand),
    .newValue (newValue),
    .returned (returned)
  );

  // ----------------------------------------------------------
  // Memory write
  // ----------------------------------------------------------
  assign doWrite   = opIn.valid && opIn.error == errNone &&
                     (opIn.op inside {opWrite, opPush} || isOperator(opIn.op));
  assign writeData = isOperator(opIn.op) ? newValue : opIn.operand;

  always_ff @(posedge clock) begin
    if (doWrite) begin
      memory[address] <= writeData;
    end
  end

  // ----------------------------------------------------------
  // Result word
  // ----------------------------------------------------------
  always_comb begin
    nextResult.valid   = opIn.valid;
    nextResult.error   = opIn.error;                             // Passed through untouched
    nextResult.loadOut = 1'b1;
    nextResult.value   = '0;
    case (opIn.op)
      opWrite:        nextResult.value = opIn.operand;
      opRead, opPop:  nextResult.value = element;
      opSize, opAlloc: nextResult.value = `HEAP_DATA_BITS'(opIn.sizeValue);
      opPush, opFree: nextResult.loadOut = 1'b0;                 // No data to return
      default:        nextResult.value = returned;               // Element operators
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      result <= '0;
    end else begin
      result <= nextResult;
    end
  end

endmodule

//--- rtl/responseStage.sv
/*
  Output register. out only changes on an error-free response that
  carries data; otherwise it keeps its last value.
*/
`timescale 1ns/1ps
`include "heap_defs.svh"

module responseStage import heapPkg::*; (
  input  logic                        clock,
  input  logic                        resetN,
  input  heapResult                   result,
  output logic                        respValid,
  output logic [`HEAP_DATA_BITS-1:0]  out,
  output heapError                    error
);

  logic loadOut;

  assign loadOut = result.valid && result.loadOut && result.error == errNone;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      respValid <= 1'b0;
      out       <= '0;
      error     <= errNone;
    end else begin
      respValid <= result.valid;                                 // One pulse per command
      if (result.valid) begin
        error <= result.error;
      end
      if (loadOut) begin
        out <= result.value;
      end
    end
  end

endmodule

//--- rtl/heapTop.sv
/*
  Array heap top level. One command per cycle may be strobed in and each
  gets exactly one response, in order, three cycles later.
  There is no back-pressure.
*/
`timescale 1ns/1ps
`include "heap_defs.svh"

module heapTop import heapPkg::*; (
  input  logic                        clock,
  input  logic                        resetN,
  input  logic                        cmdValid,
  input  heapCmd                      cmd,
  output logic                        respValid,
  output logic [`HEAP_DATA_BITS-1:0]  out,
  output heapError                    error
);

  checkedOp  checked;                                            // Allocator to store
  heapResult stored;                                             // Store to response

  // ----------------------------------------------------------
  // Checks and allocation state
  // ----------------------------------------------------------
  arrayAllocator allocator (
    .clock    (clock),
    .resetN   (resetN),
    .cmdValid (cmdValid),
    .cmd      (cmd),
    .opOut    (checked)
  );

  // ----------------------------------------------------------
  // Element memory
  // ----------------------------------------------------------
  elementStore store (
    .clock  (clock),
    .resetN (resetN),
    .opIn   (checked),
    .result (stored)
  );

  // ----------------------------------------------------------
  // Response registers
  // ----------------------------------------------------------
  responseStage response (
    .clock     (clock),
    .resetN    (resetN),
    .result    (stored),
    .respValid (respValid),
    .out       (out),
    .error     (error)
  );

endmodule

//--- sim/heap_checker.sv
/*
  Response timing checks bound into heapTop.
  Latency checks pause while resetN is low.
*/
`timescale 1ns/1ps
`include "heap_defs.svh"

module heapChecker import heapPkg::*; (
  input logic                        clock,
  input logic                        resetN,
  input logic                        cmdValid,
  input logic                        respValid,
  input logic [`HEAP_DATA_BITS-1:0]  out,
  input heapError                    error
);

  responseAfterCommand: assert property (
    @(posedge clock) disable iff (!resetN) cmdValid |-> ##`HEAP_LATENCY respValid
  ) else $error("respValid missing %0d cycles after cmdValid", `HEAP_LATENCY);

  // No response without a command
  commandBeforeResponse: assert property (
    @(posedge clock) disable iff (!resetN) respValid |-> $past(cmdValid, `HEAP_LATENCY)
  ) else $error("respValid without a matching cmdValid");

  quietInReset: assert property (
    @(posedge clock) !resetN |-> !respValid
  ) else $error("respValid high during reset");

  outHeldOnError: assert property (
    @(posedge clock) disable iff (!resetN) (respValid && error != errNone) |-> $stable(out)
  ) else $error("out changed on an error response");

endmodule

bind heapTop heapChecker timingCheck (
  .clock     (clock),
  .resetN    (resetN),
  .cmdValid  (cmdValid),
  .respValid (respValid),
  .out       (out),
  .error     (error)
);

//--- sim/heapTb.sv
/*
  Testbench for heapTop. Expected responses come from a model of the
  heap rules, in command order. Element reads touch written slots only.
*/
`timescale 1ns/1ps
`include "heap_defs.svh"

module heapTb import heapPkg::*; ();

  localparam int ResponseTimeout = 10;                           // Cycles without a response
  localparam int DrainTimeout    = 40;

  typedef logic [`HEAP_DATA_BITS-1:0] word;
  typedef struct packed {
    word      out;
    heapError error;
  } expectedResp;

  logic     clock = 1'b0;
  logic     resetN;
  logic     cmdValid;
  heapCmd   cmd;
  logic     respValid;
  word      out;
  heapError error;

  expectedResp expectQ [$];                                      // Oldest command first
  int  checks = 0;
  int  errors = 0;
  int  checksAtStart = 0;
  int  errorsAtStart = 0;

  // ----------------------------------------------------------
  // Reference model state
  // ----------------------------------------------------------
  word modelMem  [`HEAP_ARRAYS][`HEAP_LENGTH];
  int  modelSize [`HEAP_ARRAYS];
  bit  modelLive [`HEAP_ARRAYS];
  bit  modelUsed [`HEAP_ARRAYS];                                 // Allocated at least once
  int  modelFree [$];
  int  modelNext = 0;
  word modelOut  = '0;

  always #20 clock = ~clock;                                     // 40 ns period

  heapTop DUT (.clock, .resetN, .cmdValid, .cmd, .respValid, .out, .error);

  function automatic word applyOperator(heapOp op, word x, word y);
    case (op)
      opAdd, opAddAfter:      return x + y;
      opSubtract, opSubAfter: return x - y;
      opShiftLeft:            return (y >= `HEAP_DATA_BITS) ? '0 : x << y;
      opShiftRight:           return (y >= `HEAP_DATA_BITS) ? '0 : x >> y;
      opNotLogical:           return (x == '0) ? word'(1) : '0;
      opNot:                  return ~x;
      opOr:                   return x | y;
      opXor:                  return x ^ y;
      default:                return x & y;
    endcase
  endfunction

  function automatic expectedResp predictResponse(heapCmd c);
    expectedResp r;
    heapError    e;
    int          a;
    int          idx;
    int          size;
    bit          load;
    bit          elementOp;
    word         value;
    a         = c.array;
    idx       = c.index;
    size      = modelSize[a];
    elementOp = c.op inside {opAdd, opAddAfter, opSubtract, opSubAfter, opShiftLeft,
                             opShiftRight, opNotLogical, opNot, opOr, opXor, opAnd};
    e = errNone;
    if (c.op != opAlloc && !modelUsed[a]) e = errNotAllocated;
    else if (c.op == opFree && !modelLive[a]) e = errDoubleFree;
    else if (c.op != opAlloc && !modelLive[a]) e = errNotAllocated;
    else if ((c.op == opRead || elementOp) && idx >= size) e = errOutOfBounds;
    else if (c.op == opWrite && idx >= `HEAP_LENGTH) e = errOutOfBounds;
    else if (c.op == opPush && size == `HEAP_LENGTH) e = errFull;
    else if (c.op == opPop && size == 0) e = errEmpty;
    else if (c.op == opAlloc && modelFree.size() == 0 && modelNext == `HEAP_ARRAYS) begin
      e = errOutOfMemory;
    end
    if (e == errNone) begin
      load  = 1'b1;
      value = '0;
      case (c.op)
        opAlloc: begin
          if (modelFree.size() != 0) begin
            a = modelFree.pop_back();                            // Last freed goes first
          end else begin
            a         = modelNext;
            modelNext = modelNext + 1;
          end
          modelLive[a] = 1'b1;
          modelUsed[a] = 1'b1;
          modelSize[a] = 0;
          value        = word'(a);
        end
        opFree: begin
          modelLive[a] = 1'b0;
          modelFree.push_back(a);
          load = 1'b0;
        end
        opWrite: begin
          modelMem[a][idx] = c.operand;
          modelSize[a]     = (idx >= size) ? idx + 1 : size;
          value            = c.operand;
        end
        opRead: value = modelMem[a][idx];
        opSize: value = word'(size);
        opPush: begin
          modelMem[a][size] = c.operand;
          modelSize[a]      = size + 1;
          load              = 1'b0;
        end
        opPop: begin
          modelSize[a] = size - 1;
          value        = modelMem[a][size-1];
        end
        default: begin
          value            = modelMem[a][idx];
          modelMem[a][idx] = applyOperator(c.op, value, c.operand);
          if (!(c.op inside {opAddAfter, opSubAfter})) value = modelMem[a][idx];
        end
      endcase
      if (load) modelOut = value;
    end
    r.out   = modelOut;                                          // Held on error or no data
    r.error = e;
    return r;
  endfunction

  // ----------------------------------------------------------
  // Stimulus, checks and reporting
  // ----------------------------------------------------------
  task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  task automatic sendCommand(heapOp op, int array, int index, word operand);
    heapCmd c;
    c.op      = op;
    c.array   = `HEAP_ARRAY_BITS'(array);
    c.index   = `HEAP_INDEX_BITS'(index);
    c.operand = operand;
    @(posedge clock);
    cmdValid <= 1'b1;
    cmd      <= c;
    expectQ.push_back(predictResponse(c));
  endtask

  task automatic drainResponses();
    int waited;
    @(posedge clock);
    cmdValid <= 1'b0;
    waited = 0;
    while (expectQ.size() != 0 && waited < DrainTimeout) begin
      @(posedge clock);
      waited++;
    end
    if (expectQ.size() != 0) begin
      errors++;
      $display("Responses still missing %0d cycles after the last command", DrainTimeout);
    end
  endtask

  task automatic reportTest(string name);
    $display("%-14s %0d checks, %0d mismatches", name, checks - checksAtStart,
             errors - errorsAtStart);
    checksAtStart = checks;
    errorsAtStart = errors;
  endtask

  initial begin : compareResponses
    expectedResp want;
    int          idle;
    bit          timedOut;
    idle     = 0;
    timedOut = 1'b0;
    while (!timedOut) begin
      @(negedge clock);                                          // Outputs settled here
      if (respValid === 1'b1) begin
        idle = 0;
        if (expectQ.size() == 0) begin
          errors++;
          $display("Response at %0t with no command outstanding", $time);
        end else begin
          want = expectQ.pop_front();
          checkValue("out", 32'(out), 32'(want.out));
          checkValue("error", 32'(error), 32'(want.error));
        end
      end else if (expectQ.size() != 0) begin
        idle++;
        timedOut = idle > ResponseTimeout;
      end else begin
        idle = 0;
      end
    end
    $display("No response within %0d cycles of a command", ResponseTimeout);
    $display("TB FAILED");
    $finish;
  end

  initial begin : mainSequence
    heapOp operators [11];
    heapOp op;
    word   data;
    void'($urandom(82025));
    operators = '{opAdd, opAddAfter, opSubtract, opSubAfter, opShiftLeft, opShiftRight,
                  opNotLogical, opNot, opOr, opXor, opAnd};
    resetN   <= 1'b0;
    cmdValid <= 1'b0;
    cmd      <= '0;
    repeat (8) @(posedge clock);
    resetN <= 1'b1;

    repeat (6) @(negedge clock) checkValue("respValid", 32'(respValid), 0);
    for (int i = 0; i <= `HEAP_ARRAYS; i++) begin
      sendCommand(opAlloc, 0, 0, '0);                            // Last one runs out
    end
    drainResponses();
    reportTest("alloc order");

    sendCommand(opFree, 5, 0, '0);
    sendCommand(opFree, 2, 0, '0);
    sendCommand(opAlloc, 0, 0, '0);
    sendCommand(opAlloc, 0, 0, '0);
    sendCommand(opFree, 3, 0, '0);
    sendCommand(opFree, 3, 0, '0);
    sendCommand(opRead, 3, 0, '0);
    drainResponses();
    reportTest("free reuse");

    for (int i = 0; i < 4; i++) begin
      sendCommand(opWrite, 0, i, word'($urandom));
    end
    sendCommand(opSize, 0, 0, '0);
    sendCommand(opRead, 0, 3, '0);
    sendCommand(opRead, 0, 4, '0);
    drainResponses();
    reportTest("write read");

    for (int i = 0; i <= `HEAP_LENGTH; i++) begin
      sendCommand(opPush, 1, 0, word'($urandom));
    end
    for (int i = 0; i <= `HEAP_LENGTH; i++) begin
      sendCommand(opPop, 1, 0, '0);
    end
    drainResponses();
    reportTest("push pop");

    sendCommand(opWrite, 6, 0, word'(100));
    sendCommand(opAddAfter, 6, 0, word'(5));
    sendCommand(opSubAfter, 6, 0, word'(7));
    sendCommand(opRead, 6, 0, '0);
    for (int i = 0; i < `HEAP_LENGTH; i++) begin
      sendCommand(opWrite, 4, i, word'($urandom));
    end
    for (int i = 0; i < 200; i++) begin
      op   = operators[$urandom % 11];
      data = (op inside {opShiftLeft, opShiftRight}) ? word'($urandom % 20) : word'($urandom);
      sendCommand(op, 4, $urandom % `HEAP_LENGTH, data);
    end
    for (int i = 0; i < `HEAP_LENGTH; i++) begin
      sendCommand(opRead, 4, i, '0);
    end
    drainResponses();
    reportTest("operator mix");

    $display("Checks: %0d, failures: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+rtl
rtl/heapPkg.sv
rtl/elementAlu.sv
rtl/arrayAllocator.sv
rtl/elementStore.sv
rtl/responseStage.sv
rtl/heapTop.sv
sim/heap_checker.sv
sim/heapTb.sv

//--- Makefile
# Verilator build and run for the array heap testbench

VERILATOR ?= verilator
TOP       ?= heapTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TB PASSED

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(FILELIST) $(wildcard rtl/*.sv rtl/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
	  echo "Simulation result: pass"; \
	else \
	  echo "Simulation result: fail"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
